// ==== flist.f ====
verilog/memPkg.sv
verilog/byteRam.sv
verilog/storeSerializer.sv
verilog/loadAssembler.sv
verilog/memArbiter.sv
verilog/memSubsystem.sv
verification/memSubsystem_sva.sv
verification/memSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/memSubsystemTb.sv ====
`timescale 1ns/1ns

module memSubsystemTb;

    localparam int ramAddrBits = 12;
    localparam int numTrans = 90;

    logic clk = 1'b0;
    logic rst;
    logic stall = 1'b0;
    logic stallOn;
    logic stallPick;
    memPkg::fetchReq_t fetchReq;
    logic fetchReqValid;
    logic fetchReqReady;
    memPkg::memResp_t fetchResp;
    logic fetchRespValid;
    logic fetchRespReady;
    memPkg::dataReq_t dataReq;
    logic dataReqValid;
    logic dataReqReady;
    memPkg::memResp_t dataResp;
    logic dataRespValid;
    logic dataRespReady;

    logic [7:0] model [1 << ramAddrBits];
    integer seed = 32'h607a;
    int errors = 0;
    int passCount = 0;
    int failCount = 0;
    int fetchAccepts = 0;

    memSubsystem #(.ramAddrBits(ramAddrBits)) i_dut (.*);

    bind memSubsystem memSubsystem_sva sva (.*);

    always #50 clk = ~clk;

    // stall pattern is drawn on the rising edge and applied on the falling edge
    always @(posedge clk) begin
        stallPick = stallOn && (($random(seed) & 3) == 0);
        @(negedge clk);
        stall <= stallPick;
    end

    // fetch handshakes seen by the DUT
    always @(posedge clk) begin
        if (!rst && fetchReqValid && fetchReqReady && !stall) begin
            fetchAccepts++;
        end
    end

    initial begin
        #((numTrans * 20 + 200) * 100);
        $display("timeout: the DUT stopped answering");
        $display("Testbench failed");
        $finish;
    end

    function automatic int sizeBytes(memPkg::sizeCode_t size);
        return (size == memPkg::sizeByte) ? 1 : (size == memPkg::sizeHalf) ? 2 : 4;
    endfunction

    // little-endian read, bytes past the size stay zero
    function automatic logic [31:0] modelRead(logic [31:0] addr, int n);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            r[8*i +: 8] = model[ramAddrBits'(addr + i)];
        end
        return r;
    endfunction

    task automatic issueData(logic [31:0] addr, logic [31:0] wdata, logic store,
                             memPkg::sizeCode_t size);
        @(negedge clk);
        dataReq.addr = addr;
        dataReq.wdata.word = wdata;
        dataReq.store = store;
        dataReq.size = size;
        dataReqValid = 1'b1;
        do @(posedge clk); while (!(dataReqReady && !stall));
        if (store) begin
            for (int i = 0; i < sizeBytes(size); i++) begin
                model[ramAddrBits'(addr + i)] = wdata[8*i +: 8];
            end
        end
        @(negedge clk);
        dataReqValid = 1'b0;
    endtask

    task automatic issueFetch(logic [31:0] addr);
        @(negedge clk);
        fetchReq.addr = addr;
        fetchReqValid = 1'b1;
        do @(posedge clk); while (!(fetchReqReady && !stall));
        @(negedge clk);
        fetchReqValid = 1'b0;
    endtask

    // starts on the first falling edge after acceptance
    // expLat 0 skips the latency check
    task automatic collectResp(logic isData, logic [31:0] expected, int expLat, int hold);
        int n;
        logic [31:0] got;
        n = 1;
        while (!(isData ? dataRespValid : fetchRespValid)) begin
            @(negedge clk);
            if (!(isData ? dataRespValid : fetchRespValid)) n++;
        end
        got = isData ? dataResp.data.word : fetchResp.data.word;
        assert (got === expected) else begin
            errors++;
            $display("error at %0t: response %h, expected %h", $time, got, expected);
        end
        if (expLat > 0) begin
            assert (n == expLat) else begin
                errors++;
                $display("error at %0t: latency %0d, expected %0d", $time, n, expLat);
            end
        end
        repeat (hold) begin
            @(negedge clk);
            assert ((isData ? dataResp.data.word : fetchResp.data.word) === got
                    && !dataReqReady && !fetchReqReady) else begin
                errors++;
                $display("error at %0t: response moved or request ready while held", $time);
            end
        end
        if (isData) dataRespReady = 1'b1;
        else fetchRespReady = 1'b1;
        do @(negedge clk); while (isData ? dataRespValid : fetchRespValid);
        dataRespReady = 1'b0;
        fetchRespReady = 1'b0;
    endtask

    task automatic storeCheck(logic [31:0] addr, logic [31:0] data, memPkg::sizeCode_t size);
        issueData(addr, data, 1'b1, size);
        collectResp(1'b1, 32'd0, stallOn ? 0 : sizeBytes(size), 0);
    endtask

    task automatic loadCheck(logic [31:0] addr, memPkg::sizeCode_t size, int hold);
        issueData(addr, 32'd0, 1'b0, size);
        collectResp(1'b1, modelRead(addr, sizeBytes(size)), stallOn ? 0 : sizeBytes(size), hold);
    endtask

    task automatic fetchCheck(logic [31:0] addr);
        issueFetch(addr);
        collectResp(1'b0, modelRead(addr, 4), stallOn ? 0 : 4, 0);
    endtask

    task automatic report(int num, string name, int errBefore);
        if (errors == errBefore) begin
            passCount++;
            $display("test %0d %s: ok", num, name);
        end else begin
            failCount++;
            $display("test %0d %s: FAILED", num, name);
        end
    endtask

    initial begin
        int e;
        int kind;
        logic [31:0] a;
        int acceptsBefore;
        rst = 1'b1;
        stallOn = 1'b0;
        fetchReq = '0;
        fetchReqValid = 1'b0;
        fetchRespReady = 1'b0;
        dataReq = '0;
        dataReqValid = 1'b0;
        dataRespReady = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e = errors;
        a = $random(seed) & 32'hffc;
        storeCheck(a, $random(seed), memPkg::sizeWord);
        fetchCheck(a);
        report(1, "store then fetch", e);

        e = errors;
        a = 32'h200;
        storeCheck(a, 32'h8899aabb, memPkg::sizeWord);
        storeCheck(a + 1, 32'hdead1234, memPkg::sizeHalf);
        loadCheck(a + 2, memPkg::sizeByte, 0);
        loadCheck(a, memPkg::sizeHalf, 0);
        loadCheck(a, memPkg::sizeWord, 0);
        report(2, "byte and half loads", e);

        e = errors;
        acceptsBefore = fetchAccepts;
        @(negedge clk);
        fetchReq.addr = a;
        fetchReqValid = 1'b1;
        dataReq.addr = a + 4;
        dataReq.wdata.word = 32'h0badf00d;
        dataReq.store = 1'b1;
        dataReq.size = memPkg::sizeWord;
        dataReqValid = 1'b1;
        do @(posedge clk); while (!(dataReqReady && !stall));
        assert (!fetchReqReady) else begin
            errors++;
            $display("error at %0t: fetch ready beside a data request", $time);
        end
        for (int i = 0; i < 4; i++) model[ramAddrBits'(a + 4 + i)] = 8'(32'h0badf00d >> (8 * i));
        @(negedge clk);
        dataReqValid = 1'b0;
        collectResp(1'b1, 32'd0, 4, 0);
        assert (fetchAccepts == acceptsBefore) else begin
            errors++;
            $display("error at %0t: fetch accepted before the data request completed", $time);
        end
        do @(posedge clk); while (!(fetchReqReady && !stall));
        @(negedge clk);
        fetchReqValid = 1'b0;
        collectResp(1'b0, modelRead(a, 4), 4, 0);
        report(3, "data before fetch", e);

        e = errors;
        stallOn = 1'b1;
        // fill one word past the window so accesses near its top never see unwritten bytes
        for (int i = 0; i < 17; i++) begin
            storeCheck(i * 4, {8'(i), 8'(i ^ 8'h5a), 8'(~i), 8'(i * 3)}, memPkg::sizeWord);
        end
        for (int i = 0; i < 40; i++) begin
            kind = $random(seed) & 3;
            a = $random(seed) & 32'h3c;
            a = a + ($random(seed) & 3);
            if (kind == 0) fetchCheck(a);
            else if (kind == 1) storeCheck(a, $random(seed), memPkg::sizeCode_t'(i % 3));
            else loadCheck(a, memPkg::sizeCode_t'(i % 3), 0);
        end
        stallOn = 1'b0;
        @(negedge clk);
        report(4, "random stall", e);

        e = errors;
        storeCheck(32'h340, 32'h13572468, memPkg::sizeWord);
        loadCheck(32'h340, memPkg::sizeWord, 6);
        fetchCheck(32'h340);
        report(5, "response back-pressure", e);

        e = errors;
        storeCheck(32'h0000_1ffe, 32'hcafe4321, memPkg::sizeWord);
        fetchCheck(32'h0000_0ffe);
        loadCheck(32'habcd_0000, memPkg::sizeWord, 0);
        loadCheck(32'h0000_0fff, memPkg::sizeHalf, 0);
        report(6, "address wrap", e);

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verification/memSubsystem_sva.sv ====
`timescale 1ns/1ns

module memSubsystem_sva (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic             fetchReqReady,
    input memPkg::memResp_t fetchResp,
    input logic             fetchRespValid,
    input logic             fetchRespReady,
    input logic             dataReqReady,
    input memPkg::memResp_t dataResp,
    input logic             dataRespValid,
    input logic             dataRespReady
);

    // a response waits for its ready with unchanged data
    fetchRespHeld: assert property (@(posedge clk) disable iff (rst)
        fetchRespValid && !fetchRespReady |=> fetchRespValid && $stable(fetchResp))
        else $error("fetch response dropped or changed before its handshake");

    dataRespHeld: assert property (@(posedge clk) disable iff (rst)
        dataRespValid && !dataRespReady |=> dataRespValid && $stable(dataResp))
        else $error("data response dropped or changed before its handshake");

    // an idle controller stays idle through a stalled cycle
    stallNoAccept: assert property (@(posedge clk) disable iff (rst)
        stall && dataReqReady |=> dataReqReady)
        else $error("request accepted while stall was high");

    stallFrozenResp: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(fetchRespValid) && $stable(dataRespValid))
        else $error("response valid moved while stall was high");

    pendingBlocksReq: assert property (@(posedge clk) disable iff (rst)
        fetchRespValid || dataRespValid |-> !fetchReqReady && !dataReqReady)
        else $error("request ready high while a response was pending");

endmodule

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/1ns

module memSubsystem #(
    parameter int ramAddrBits = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  memPkg::fetchReq_t fetchReq,
    input  logic              fetchReqValid,
    output logic              fetchReqReady,
    output memPkg::memResp_t  fetchResp,
    output logic              fetchRespValid,
    input  logic              fetchRespReady,
    input  memPkg::dataReq_t  dataReq,
    input  logic              dataReqValid,
    output logic              dataReqReady,
    output memPkg::memResp_t  dataResp,
    output logic              dataRespValid,
    input  logic              dataRespReady
);

    logic [31:0]      ramAddr;
    logic             ramWrite;
    logic [1:0]       byteIdx;
    logic             captureEn;
    logic             loadEn;
    logic             clear;
    logic             respToData;
    logic [7:0]       readByte;
    logic [7:0]       writeByte;
    memPkg::memResp_t word;

    memArbiter arbiter (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .fetchReq       (fetchReq),
        .fetchReqValid  (fetchReqValid),
        .fetchReqReady  (fetchReqReady),
        .fetchRespValid (fetchRespValid),
        .fetchRespReady (fetchRespReady),
        .dataReq        (dataReq),
        .dataReqValid   (dataReqValid),
        .dataReqReady   (dataReqReady),
        .dataRespValid  (dataRespValid),
        .dataRespReady  (dataRespReady),
        .ramAddr        (ramAddr),
        .ramWrite       (ramWrite),
        .byteIdx        (byteIdx),
        .captureEn      (captureEn),
        .loadEn         (loadEn),
        .clear          (clear),
        .respToData     (respToData)
    );

    loadAssembler assembler (
        .clk       (clk),
        .rst       (rst),
        .captureEn (captureEn),
        .byteIdx   (byteIdx),
        .readByte  (readByte),
        .clear     (clear),
        .word      (word)
    );

    storeSerializer serializer (
        .clk       (clk),
        .rst       (rst),
        .loadEn    (loadEn),
        .storeWord (dataReq.wdata),
        .byteIdx   (byteIdx),
        .writeByte (writeByte)
    );

    // upper address bits drop off, so accesses wrap around the RAM
    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) ram (
        .clk       (clk),
        .addr      (ramAddr[ramAddrBits-1:0]),
        .write     (ramWrite),
        .writeByte (writeByte),
        .readByte  (readByte)
    );

    // assembled word goes to the port that owns the access
    assign fetchResp = respToData ? '0 : word;
    assign dataResp  = respToData ? word : '0;

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ns

module memArbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  memPkg::fetchReq_t fetchReq,
    input  logic              fetchReqValid,
    output logic              fetchReqReady,
    output logic              fetchRespValid,
    input  logic              fetchRespReady,
    input  memPkg::dataReq_t  dataReq,
    input  logic              dataReqValid,
    output logic              dataReqReady,
    output logic              dataRespValid,
    input  logic              dataRespReady,
    output logic [31:0]       ramAddr,
    output logic              ramWrite,
    output logic [1:0]        byteIdx,
    output logic              captureEn,
    output logic              loadEn,
    output logic              clear,
    output logic              respToData
);

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore,
        stRespond
    } state_t;

    state_t      state;
    logic [31:0] baseAddr;
    logic [1:0]  lastIdx;
    logic [1:0]  idx;
    logic        ownerData;
    logic        capPend;

    logic        fetchAccept;
    logic        dataAccept;
    logic        reading;
    logic        respDone;

    // data side wins when both ask in the same cycle
    assign dataReqReady  = (state == stIdle);
    assign fetchReqReady = (state == stIdle) && !dataReqValid;

    assign dataAccept  = dataReqValid && dataReqReady && !stall;
    assign fetchAccept = fetchReqValid && fetchReqReady && !stall;

    assign clear  = dataAccept || fetchAccept;
    assign loadEn = dataAccept && dataReq.store;

    assign reading = (state == stFetch) || (state == stLoad);

    assign ramAddr  = baseAddr + {30'd0, idx};
    assign byteIdx  = idx;
    assign ramWrite = (state == stStore) && !stall;

    // readByte holds the byte addressed on the last advancing cycle
    assign captureEn = capPend;

    assign fetchRespValid = (state == stRespond) && !ownerData;
    assign dataRespValid  = (state == stRespond) && ownerData;
    assign respToData     = ownerData;
    assign respDone       = ownerData ? dataRespReady : fetchRespReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            capPend <= 1'b0;
        end else begin
            capPend <= reading && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            idx       <= 2'd0;
            lastIdx   <= 2'd0;
            ownerData <= 1'b0;
        end else if (!stall) begin
            case (state)
                stIdle: begin
                    if (dataAccept) begin
                        baseAddr  <= dataReq.addr;
                        lastIdx   <= memPkg::lastByteIdx(dataReq.size);
                        ownerData <= 1'b1;
                        idx       <= 2'd0;
                        state     <= dataReq.store ? stStore : stLoad;
                    end else if (fetchAccept) begin
                        baseAddr  <= fetchReq.addr;
                        lastIdx   <= memPkg::fetchLastIdx;
                        ownerData <= 1'b0;
                        idx       <= 2'd0;
                        state     <= stFetch;
                    end
                end
                stFetch, stLoad, stStore: begin
                    // idx wraps after a word, leaving the last lane one step behind
                    idx <= idx + 2'd1;
                    if (idx == lastIdx) begin
                        state <= stRespond;
                    end
                end
                stRespond: begin
                    if (respDone) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

// ==== verilog/loadAssembler.sv ====
`timescale 1ns/1ns

module loadAssembler (
    input  logic             clk,
    input  logic             rst,
    input  logic             captureEn,
    input  logic [1:0]       byteIdx,
    input  logic [7:0]       readByte,
    input  logic             clear,
    output memPkg::memResp_t word
);

    memPkg::memWord_u heldWord;
    memPkg::memWord_u mergedWord;
    logic [1:0]       lane;

    // arriving byte was addressed one step before the current index
    assign lane = byteIdx - 2'd1;

    // the last byte goes straight through so the response is complete
    // on its first valid cycle
    always_comb begin
        mergedWord = heldWord;
        if (captureEn) begin
            mergedWord.lanes[lane] = readByte;
        end
    end

    // lanes never written stay zero, which zero-extends short loads
    always_ff @(posedge clk) begin
        if (rst) begin
            heldWord.word <= 32'd0;
        end else if (clear) begin
            heldWord.word <= 32'd0;
        end else if (captureEn) begin
            heldWord.lanes[lane] <= readByte;
        end
    end

    assign word.data = mergedWord;

endmodule

// ==== verilog/storeSerializer.sv ====
`timescale 1ns/1ns

module storeSerializer (
    input  logic             clk,
    input  logic             rst,
    input  logic             loadEn,
    input  memPkg::memWord_u storeWord,
    input  logic [1:0]       byteIdx,
    output logic [7:0]       writeByte
);

    memPkg::memWord_u heldWord;

    // captured at acceptance, the requester may move on afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            heldWord.word <= 32'd0;
        end else if (loadEn) begin
            heldWord <= storeWord;
        end
    end

    // little-endian, lane 0 goes to the base address
    assign writeByte = heldWord.lanes[byteIdx];

endmodule

// ==== verilog/byteRam.sv ====
`timescale 1ns/1ns

module byteRam #(
    parameter int ramAddrBits = 12
) (
    input  logic                   clk,
    input  logic [ramAddrBits-1:0] addr,
    input  logic                   write,
    input  logic [7:0]             writeByte,
    output logic [7:0]             readByte
);

    localparam int depth = 2 ** ramAddrBits;

    logic [7:0] mem [depth];

    // read returns the old byte when the same address is written
    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= writeByte;
        end
        readByte <= mem[addr];
    end

endmodule

// ==== verilog/memPkg.sv ====
package memPkg;

    // access width of a load or store
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } sizeCode_t;

    // one memory word, seen whole or as byte lanes
    // lane 0 is the byte at the lowest address
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;
    } memWord_u;

    typedef struct packed {
        logic [31:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic [31:0] addr;
        memWord_u    wdata;
        logic        store;
        sizeCode_t   size;
    } dataReq_t;

    typedef struct packed {
        memWord_u data;
    } memResp_t;

    // index of the last byte moved for a given size
    // the unused code is treated as a word
    function automatic logic [1:0] lastByteIdx(sizeCode_t size);
        logic [1:0] idx;
        case (size)
            sizeByte: begin
                idx = 2'd0;
            end
            sizeHalf: begin
                idx = 2'd1;
            end
            sizeWord: begin
                idx = 2'd3;
            end
            default: begin
                idx = 2'd3;
            end
        endcase
        return idx;
    endfunction

    // fetches always move a full instruction
    localparam logic [1:0] fetchLastIdx = 2'd3;

endpackage
